//--- logic/icache_pkg.sv
package icache_pkg;

    ////////////////////////////////////////
    // address split and cache geometry
    ////////////////////////////////////////

    localparam int ADDR_W         = 32;
    localparam int TAG_W          = 24;
    localparam int INDEX_W        = 4;
    localparam int OFFSET_W       = 4;              // byte within a line
    localparam int SETS           = 16;
    localparam int WAYS           = 4;
    localparam int WAY_W          = 2;
    localparam int WORD_W         = 32;             // one instruction
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;

    ////////////////////////////////////////
    // controller state encodings
    ////////////////////////////////////////

    localparam logic [2:0] ST_IDLE        = 3'd0;  // waiting for a fetch
    localparam logic [2:0] ST_LOOKUP      = 3'd1;  // tags valid, hit or miss known
    localparam logic [2:0] ST_REFILL_REQ  = 3'd2;  // line address presented
    localparam logic [2:0] ST_REFILL_WAIT = 3'd3;  // waiting for the line
    localparam logic [2:0] ST_RESPOND     = 3'd4;  // instruction held for the fetch side

    // field view of a fetch address
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [1:0]         word_sel;              // word within the line
        logic [1:0]         byte_sel;
    } fetch_fields_t;

    // same address seen as a flat word or as its fields
    typedef union packed {
        logic [ADDR_W-1:0] word;
        fetch_fields_t     fld;
    } fetch_addr_u;

endpackage

//--- logic/way_access_if.sv
`timescale 1ns/1ns

interface way_access_if import icache_pkg::*; ();

    // lookup side
    logic                rd_en;
    logic [INDEX_W-1:0]  rd_index;
    logic [TAG_W-1:0]    cmp_tag;

    // refill side
    logic                wr_en;
    logic [WAY_W-1:0]    wr_way;
    logic [INDEX_W-1:0]  wr_index;
    logic [TAG_W-1:0]    wr_tag;
    logic [LINE_W-1:0]   wr_line;

    // compare results
    logic                hit;
    logic [WAY_W-1:0]    hit_way;
    logic [LINE_W-1:0]   hit_line;

    modport ctrl (
        output rd_en, rd_index, cmp_tag,
        output wr_en, wr_way, wr_index, wr_tag, wr_line,
        input  hit, hit_way, hit_line
    );

    modport store (
        input  rd_en, rd_index, cmp_tag,
        input  wr_en, wr_way, wr_index, wr_tag, wr_line,
        output hit, hit_way, hit_line
    );

endinterface

//--- logic/icache_ways.sv
`timescale 1ns/1ns

module icache_ways import icache_pkg::*; (
    input  logic           clk_g,
    input  logic           arst_n,
    way_access_if.store    acc
);

    ////////////////////////////////////////
    // storage arrays
    ////////////////////////////////////////

    logic [TAG_W-1:0]             tag_mem  [WAYS][SETS];
    logic [LINE_W-1:0]            line_mem [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0]    valid_mem;

    // registered read of one set, all ways
    logic [TAG_W-1:0]             rd_tag_q  [WAYS];
    logic [LINE_W-1:0]            rd_line_q [WAYS];
    logic [WAYS-1:0]              rd_valid_q;

    always_ff @(posedge clk_g or negedge arst_n) begin
        if (!arst_n) begin
            valid_mem <= '0;                                // empty cache
        end else if (acc.wr_en) begin
            valid_mem[acc.wr_way][acc.wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_g) begin
        if (acc.wr_en) begin
            tag_mem[acc.wr_way][acc.wr_index]  <= acc.wr_tag;
            line_mem[acc.wr_way][acc.wr_index] <= acc.wr_line;
        end
    end

    ////////////////////////////////////////
    // read port
    ////////////////////////////////////////

    always_ff @(posedge clk_g or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid_q <= '0;
        end else if (acc.rd_en) begin
            for (int w = 0; w < WAYS; w++) begin
                rd_valid_q[w] <= valid_mem[w][acc.rd_index];
            end
        end
    end

    always_ff @(posedge clk_g) begin
        if (acc.rd_en) begin
            for (int w = 0; w < WAYS; w++) begin
                rd_tag_q[w]  <= tag_mem[w][acc.rd_index];
                rd_line_q[w] <= line_mem[w][acc.rd_index];
            end
        end
    end

    // tag compare on the held set, at most one way can match
    always_comb begin
        acc.hit      = 1'b0;
        acc.hit_way  = '0;
        acc.hit_line = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (rd_valid_q[w] && (rd_tag_q[w] == acc.cmp_tag)) begin
                acc.hit      = 1'b1;
                acc.hit_way  = WAY_W'(w);
                acc.hit_line = rd_line_q[w];
            end
        end
    end

endmodule

//--- logic/plru_tree.sv
`timescale 1ns/1ns

module plru_tree import icache_pkg::*; (
    input  logic                clk_g,
    input  logic                arst_n,
    input  logic                touch,
    input  logic [INDEX_W-1:0]  touch_index,
    input  logic [WAY_W-1:0]    touch_way,
    output logic [WAY_W-1:0]    victim_way
);

    // one tree per set
    logic [SETS-1:0] root_bit;                          // 1 points at ways 0-1
    logic [SETS-1:0] left_bit;                          // 1 points at way 0
    logic [SETS-1:0] right_bit;                         // 1 points at way 2

    ////////////////////////////////////////
    // victim walk
    ////////////////////////////////////////

    always_comb begin
        if (root_bit[touch_index]) begin
            victim_way = left_bit[touch_index] ? 2'd0 : 2'd1;
        end else begin
            victim_way = right_bit[touch_index] ? 2'd2 : 2'd3;
        end
    end

    ////////////////////////////////////////
    // update, bits on the path turn away
    ////////////////////////////////////////

    always_ff @(posedge clk_g or negedge arst_n) begin
        if (!arst_n) begin
            root_bit  <= '0;
            left_bit  <= '0;
            right_bit <= '0;
        end else if (touch) begin
            if (touch_way[1]) begin                     // ways 2-3 used
                root_bit[touch_index]  <= 1'b1;
                right_bit[touch_index] <= touch_way[0]; // way 3 used, point at 2
            end else begin                              // ways 0-1 used
                root_bit[touch_index]  <= 1'b0;
                left_bit[touch_index]  <= touch_way[0]; // way 1 used, point at 0
            end
        end
    end

endmodule

//--- logic/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl import icache_pkg::*; (
    input  logic                clk_g,
    input  logic                arst_n,
    input  logic                req_valid,
    output logic                req_ready,
    input  logic [ADDR_W-1:0]   req_addr,
    output logic                resp_valid,
    input  logic                resp_ready,
    output logic [WORD_W-1:0]   resp_inst,
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    output logic [ADDR_W-1:0]   mem_req_addr,
    input  logic                mem_resp_valid,
    input  logic [LINE_W-1:0]   mem_resp_line,
    output logic                touch,
    output logic [INDEX_W-1:0]  touch_index,
    output logic [WAY_W-1:0]    touch_way,
    input  logic [WAY_W-1:0]    victim_way,
    way_access_if.ctrl          ways
);

    logic [2:0]         state;
    logic [2:0]         state_nxt;
    fetch_addr_u        req_in;
    fetch_addr_u        req_q;                          // accepted fetch
    logic [WAY_W-1:0]   victim_q;                       // way chosen at the miss
    logic [WORD_W-1:0]  inst_q;
    logic [WORD_W-1:0]  hit_word;
    logic [WORD_W-1:0]  fill_word;
    logic               accept;
    logic               lookup_hit;
    logic               lookup_miss;
    logic               fill_done;

    function automatic logic [WORD_W-1:0] sel_word(input logic [LINE_W-1:0] line,
                                                   input logic [1:0]        sel);
        logic [WORD_W-1:0] w;
        w = '0;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            if (int'(sel) == k) begin
                w = line[k*WORD_W +: WORD_W];
            end
        end
        return w;
    endfunction

    assign req_in      = req_addr;
    assign accept      = req_valid && req_ready;
    assign lookup_hit  = (state == ST_LOOKUP) && ways.hit;
    assign lookup_miss = (state == ST_LOOKUP) && !ways.hit;
    assign fill_done   = (state == ST_REFILL_WAIT) && mem_resp_valid;

    assign hit_word    = sel_word(ways.hit_line, req_q.fld.word_sel);
    assign fill_word   = sel_word(mem_resp_line, req_q.fld.word_sel);

    ////////////////////////////////////////
    // way storage access
    ////////////////////////////////////////

    assign ways.rd_en    = accept;                      // read lands with LOOKUP
    assign ways.rd_index = req_in.fld.index;
    assign ways.cmp_tag  = req_q.fld.tag;
    assign ways.wr_en    = fill_done;
    assign ways.wr_way   = victim_q;
    assign ways.wr_index = req_q.fld.index;
    assign ways.wr_tag   = req_q.fld.tag;
    assign ways.wr_line  = mem_resp_line;

    assign touch       = lookup_hit || fill_done;
    assign touch_index = req_q.fld.index;
    assign touch_way   = (state == ST_LOOKUP) ? ways.hit_way : victim_q;

    ////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////

    assign req_ready     = (state == ST_IDLE);
    assign resp_valid    = lookup_hit || (state == ST_RESPOND);
    assign resp_inst     = (state == ST_RESPOND) ? inst_q : hit_word;
    assign mem_req_valid = lookup_miss || (state == ST_REFILL_REQ);
    assign mem_req_addr  = {req_q.fld.tag, req_q.fld.index, {OFFSET_W{1'b0}}};

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept) state_nxt = ST_LOOKUP;
            end
            ST_LOOKUP: begin
                if (ways.hit) begin
                    state_nxt = resp_ready ? ST_IDLE : ST_RESPOND;
                end else begin
                    state_nxt = mem_req_ready ? ST_REFILL_WAIT : ST_REFILL_REQ;
                end
            end
            ST_REFILL_REQ: begin
                if (mem_req_ready) state_nxt = ST_REFILL_WAIT;
            end
            ST_REFILL_WAIT: begin
                if (mem_resp_valid) state_nxt = ST_RESPOND;
            end
            ST_RESPOND: begin
                if (resp_ready) state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_g or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request, victim and instruction hold registers
    always_ff @(posedge clk_g) begin
        if (accept) req_q <= req_in;
        if (lookup_miss) victim_q <= victim_way;
        if (lookup_hit) begin
            inst_q <= hit_word;                         // kept if resp_ready is low
        end else if (fill_done) begin
            inst_q <= fill_word;
        end
    end

endmodule

//--- logic/icache_top.sv
`timescale 1ns/1ns

module icache_top import icache_pkg::*; (
    input  logic                clk_g,
    input  logic                arst_n,
    input  logic                req_valid,
    output logic                req_ready,
    input  logic [ADDR_W-1:0]   req_addr,
    output logic                resp_valid,
    input  logic                resp_ready,
    output logic [WORD_W-1:0]   resp_inst,
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    output logic [ADDR_W-1:0]   mem_req_addr,
    input  logic                mem_resp_valid,
    input  logic [LINE_W-1:0]   mem_resp_line
);

    logic                touch;
    logic [INDEX_W-1:0]  touch_index;
    logic [WAY_W-1:0]    touch_way;
    logic [WAY_W-1:0]    victim_way;

    way_access_if acc_if ();

    icache_ctrl u_ctrl (
        .clk_g          (clk_g),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_addr       (req_addr),
        .resp_valid     (resp_valid),
        .resp_ready     (resp_ready),
        .resp_inst      (resp_inst),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_addr   (mem_req_addr),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_line  (mem_resp_line),
        .touch          (touch),
        .touch_index    (touch_index),
        .touch_way      (touch_way),
        .victim_way     (victim_way),
        .ways           (acc_if.ctrl)
    );

    icache_ways u_ways (
        .clk_g  (clk_g),
        .arst_n (arst_n),
        .acc    (acc_if.store)
    );

    plru_tree u_plru (
        .clk_g       (clk_g),
        .arst_n      (arst_n),
        .touch       (touch),
        .touch_index (touch_index),
        .touch_way   (touch_way),
        .victim_way  (victim_way)
    );

endmodule

//--- testbench/icache_checker.sv
`timescale 1ns/1ns

module icache_checker import icache_pkg::*; (
    input logic               clk_g, arst_n,
    input logic               req_valid, req_ready, resp_valid, resp_ready,
    input logic               mem_req_valid, mem_req_ready,
    input logic [ADDR_W-1:0]  req_addr, mem_req_addr,
    input logic [WORD_W-1:0]  resp_inst
);

    int           fail_count = 0;                       // polled by the testbench
    fetch_addr_u  taken;                                // last accepted fetch

    // word k of a line is its line address plus 4k xored with a marker
    function automatic logic [WORD_W-1:0] word_for(input fetch_addr_u a);
        return {a.fld.tag, a.fld.index, a.fld.word_sel, 2'b00} ^ 32'hA5A5_0000;
    endfunction

    always_ff @(posedge clk_g) begin
        if (req_valid && req_ready) taken <= req_addr;
    end

    ////////////////////////////////////////
    // top-level protocol and data
    ////////////////////////////////////////

    resp_data: assert property (@(posedge clk_g) disable iff (!arst_n)
        resp_valid |-> resp_inst == word_for(taken))
    else begin
        fail_count++;
        $error("Error at %0t ns: resp_inst = 0x%0h, expected 0x%0h", $time,
               $sampled(resp_inst), word_for($sampled(taken)));
    end

    // refill address is the line of the accepted fetch
    line_aligned: assert property (@(posedge clk_g) disable iff (!arst_n)
        mem_req_valid |-> mem_req_addr == {taken.word[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}})
    else begin
        fail_count++;
        $error("Error at %0t ns: mem_req_addr = 0x%0h, expected 0x%0h", $time,
               $sampled(mem_req_addr), {$sampled(taken.word[ADDR_W-1:OFFSET_W]), 4'h0});
    end

    // both channels hold under back-pressure
    held_until_taken: assert property (@(posedge clk_g) disable iff (!arst_n)
        (resp_valid && !resp_ready |=> resp_valid && $stable(resp_inst)) and
        (mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr)))
    else begin
        fail_count++;
        $error("a response or memory request changed before it was taken");
    end

    reset_quiet: assert property (@(posedge clk_g) !arst_n |-> !resp_valid && !mem_req_valid)
    else begin
        fail_count++;
        $error("resp_valid or mem_req_valid was high during reset");
    end

endmodule

//--- testbench/tb_icache.sv
`timescale 1ns/1ns

module tb_icache import icache_pkg::*; ();

    localparam int TIMEOUT = 40;                        // cycles per handshake wait

    logic               clk_g, arst_n;
    logic               req_valid, req_ready, resp_valid, resp_ready;
    logic               mem_req_valid, mem_req_ready, mem_resp_valid;
    logic [ADDR_W-1:0]  req_addr, mem_req_addr;
    logic [WORD_W-1:0]  resp_inst;
    logic [LINE_W-1:0]  mem_resp_line;
    integer             seed = 32'h4795;
    int                 mem_reqs = 0;                   // memory requests taken so far

    icache_top UUT (.*);

    bind icache_top icache_checker u_checker (.*);

    initial begin
        clk_g = 1'b0;
        forever #10 clk_g = ~clk_g;
    end

    // memory request transfers
    always @(posedge clk_g) begin
        if (mem_req_valid && mem_req_ready) mem_reqs++;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        abort_run($sformatf("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge clk_g);
        #2;                                             // drive just after the edge
    endtask

    ////////////////////////////////////////
    // memory responder and fetch driver
    ////////////////////////////////////////

    task automatic serve_memory(input logic [ADDR_W-1:0] addr);
        fetch_addr_u line;
        line              = addr;
        line.fld.word_sel = 2'd0;
        line.fld.byte_sel = 2'd0;
        assert (mem_req_addr == line.word)
            else report_value("mem_req_addr", mem_req_addr, line.word);
        repeat ($unsigned($random(seed)) % 4) next_cycle();     // accept after 0-3 cycles
        mem_req_ready = 1'b1;
        next_cycle();
        mem_req_ready = 1'b0;
        repeat (1 + $unsigned($random(seed)) % 4) next_cycle();
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            mem_resp_line[k*WORD_W +: WORD_W] = (line.word + 4 * k) ^ 32'hA5A5_0000;
        end
        mem_resp_valid = 1'b1;                          // one-cycle pulse
        next_cycle();
        mem_resp_valid = 1'b0;
    endtask

    task automatic fetch(input logic [ADDR_W-1:0] addr, input bit expect_hit, input bit stall);
        int waited;
        int reqs_before;
        waited      = 0;
        reqs_before = mem_reqs;
        req_valid   = 1'b1;
        req_addr    = addr;
        resp_ready  = !stall;
        while (!req_ready) begin
            waited++;
            if (waited > TIMEOUT) abort_run("req_ready stayed low, fetch was never accepted");
            next_cycle();
        end
        next_cycle();                                   // request taken here
        req_valid = 1'b0;
        assert (!req_ready) else report_value("req_ready", req_ready, 0);
        assert (resp_valid == expect_hit)
            else report_value("resp_valid", resp_valid, expect_hit);
        if (mem_req_valid) begin
            serve_memory(addr);
            assert (resp_valid) else report_value("resp_valid", resp_valid, 1);
        end
        if (stall) begin
            repeat (1 + $unsigned($random(seed)) % 4) next_cycle();
            resp_ready = 1'b1;
        end
        next_cycle();                                   // response taken
        assert (mem_reqs - reqs_before == (expect_hit ? 0 : 1))
            else report_value("memory requests", mem_reqs - reqs_before, expect_hit ? 0 : 1);
    endtask

    initial begin
        arst_n         = 1'b0;
        req_valid      = 1'b0;
        req_addr       = '0;
        resp_ready     = 1'b1;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_line  = '0;
        repeat (8) @(posedge clk_g);
        #2 arst_n = 1'b1;
        next_cycle();
        assert (req_ready && !resp_valid && !mem_req_valid)
            else abort_run("the cache was not idle after reset");
        fetch(32'h0000_1234, 1'b0, 1'b0);               // cold miss
        for (int k = 0; k < 4; k++) fetch(32'h0000_1230 + 4 * k, 1'b1, 1'b0);
        // four tags fill set 5 and then hit
        for (int t = 1; t <= 4; t++) fetch(32'h50 + 32'h100 * t, 1'b0, 1'b0);
        for (int t = 1; t <= 4; t++) fetch(32'h50 + 32'h100 * t, 1'b1, 1'b0);
        fetch(32'h0000_0550, 1'b0, 1'b0);               // evicts tag 1
        fetch(32'h0000_0154, 1'b0, 1'b0);
        // in set 9 a hit on tag 1 moves the victim to tag 2
        for (int t = 1; t <= 4; t++) fetch(32'h90 + 32'h100 * t, 1'b0, 1'b0);
        fetch(32'h0000_0190, 1'b1, 1'b0);
        fetch(32'h0000_0598, 1'b0, 1'b0);
        fetch(32'h0000_019C, 1'b1, 1'b0);
        fetch(32'h0000_0294, 1'b0, 1'b0);
        // response back-pressure over two lines of set 12
        for (int k = 0; k < 8; k++) begin
            fetch(32'h00AB_CDC0 + 32'h100 * (k / 4) + 4 * (k % 4), k % 4 != 0, 1'b1);
        end
        next_cycle();
        if (UUT.u_checker.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            abort_run("an assertion in icache_checker failed");
        end
    end

    always @(negedge clk_g) begin
        if (UUT.u_checker.fail_count != 0) abort_run("an assertion in icache_checker failed");
    end

endmodule

//--- verilog.f
logic/icache_pkg.sv
logic/way_access_if.sv
logic/icache_ways.sv
logic/plru_tree.sv
logic/icache_ctrl.sv
logic/icache_top.sv
testbench/icache_checker.sv
testbench/tb_icache.sv
